//--- design/icache_pkg.sv
// shared geometry, address fields and fill/request types
// for the four-way VIPT instruction cache

package icache_pkg;

  // geometry
  localparam int ways              = 4;
  localparam int sets              = 64;
  localparam int block_words       = 4;
  localparam int paddr_width       = 32;
  localparam int page_offset_width = 12;

  // derived widths
  localparam int index_width       = 6;
  localparam int word_offset_width = 2;
  localparam int byte_offset_width = 3;
  localparam int tag_width         = 21;
  localparam int ptag_width        = 20;
  localparam int way_id_width      = 2;
  localparam int dword_width       = 64;
  localparam int instr_width       = 32;
  localparam int lru_width         = 3;
  localparam int block_width       = block_words * dword_width;

  typedef struct packed {
    logic [tag_width-1:0]         tag;
    logic [index_width-1:0]       index;
    logic [word_offset_width-1:0] word_offset;
    logic [byte_offset_width-1:0] byte_offset;
  } addr_fields_s;

  typedef logic [way_id_width-1:0] way_id_t;

  typedef enum logic [1:0] {
    fill_set_clear  = 2'd0,
    fill_invalidate = 2'd1,
    fill_set_tag    = 2'd2,
    fill_write_data = 2'd3
  } fill_op_e;

  // tag view of the payload, tag in the low bits
  typedef struct packed {
    logic [block_width-tag_width-2:0] pad;
    logic                             valid;
    logic [tag_width-1:0]             tag;
  } tag_info_s;

  // opcode picks which view applies
  typedef union packed {
    logic [block_words-1:0][dword_width-1:0] block;
    tag_info_s                               tag_info;
  } fill_payload_u;

  typedef struct packed {
    fill_op_e                 op;
    logic [index_width-1:0]   index;
    way_id_t                  way;
    fill_payload_u            payload;
  } fill_pkt_s;

  typedef struct packed {
    logic [paddr_width-1:0] addr;
  } cache_req_s;

  typedef struct packed {
    way_id_t victim;
  } cache_meta_s;

endpackage

//--- design/icache_tag_array.sv
// tag and valid storage per set and way
// fill packet decode and synchronous lookup read

module icache_tag_array
  import icache_pkg::*;
(
  input  logic                              clk_i,
  input  logic                              reset_i,
  input  logic                              lookup_en_i,
  input  logic [index_width-1:0]            lookup_index_i,
  input  logic                              fill_en_i,
  input  fill_pkt_s                         fill_pkt_i,
  output logic [ways-1:0][tag_width-1:0]    tags_o,
  output logic [ways-1:0]                   valid_o
);

  logic [ways-1:0][tag_width-1:0] tag_mem [sets];
  logic [ways-1:0]                valid_r [sets];
  tag_info_s                      fill_tag;

  assign fill_tag = fill_pkt_i.payload.tag_info;

  // valid bits are cleared by reset
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int s = 0; s < sets; s++) begin
        valid_r[s] <= '0;
      end
    end else if (fill_en_i) begin
      case (fill_pkt_i.op)
        fill_set_clear:  valid_r[fill_pkt_i.index] <= '0;
        fill_invalidate: valid_r[fill_pkt_i.index][fill_pkt_i.way] <= 1'b0;
        fill_set_tag:    valid_r[fill_pkt_i.index][fill_pkt_i.way] <= fill_tag.valid;
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (fill_en_i) begin
      case (fill_pkt_i.op)
        fill_set_clear: tag_mem[fill_pkt_i.index] <= '0;
        fill_set_tag:   tag_mem[fill_pkt_i.index][fill_pkt_i.way] <= fill_tag.tag;
        default: ;
      endcase
    end
  end

  // lookup read, visible in the cycle after
  always_ff @(posedge clk_i) begin
    if (lookup_en_i) begin
      tags_o  <= tag_mem[lookup_index_i];
      valid_o <= valid_r[lookup_index_i];
    end
  end

  // miss_ctrl shares one port between lookups and fills
  a_port_exclusive: assert property (
    @(posedge clk_i) disable iff (reset_i)
    !(lookup_en_i && fill_en_i)
  );

endmodule

//--- design/icache_data_banks.sv
// four dword banks with address swizzle
// bank b at offset o holds word o of way b^o
// block fills go through a write butterfly

module icache_data_banks
  import icache_pkg::*;
(
  input  logic                                 clk_i,
  input  logic                                 lookup_en_i,
  input  logic [index_width-1:0]               lookup_index_i,
  input  logic [word_offset_width-1:0]         lookup_offset_i,
  input  logic                                 fill_en_i,
  input  fill_pkt_s                            fill_pkt_i,
  output logic [ways-1:0][dword_width-1:0]     bank_data_o
);

  logic write_en;

  assign write_en = fill_en_i && (fill_pkt_i.op == fill_write_data);

  for (genvar b = 0; b < ways; b++) begin : g_bank
    logic [dword_width-1:0]       mem [sets*block_words];
    logic [word_offset_width-1:0] wr_offset;
    logic [dword_width-1:0]       wr_data;

    // bank b takes word w^b of the block
    assign wr_offset = fill_pkt_i.way ^ word_offset_width'(b);
    assign wr_data   = fill_pkt_i.payload.block[wr_offset];

    always_ff @(posedge clk_i) begin
      if (lookup_en_i) begin
        // every bank reads the same offset
        bank_data_o[b] <= mem[{lookup_index_i, lookup_offset_i}];
      end else if (write_en) begin
        mem[{fill_pkt_i.index, wr_offset}] <= wr_data;
      end
    end
  end

endmodule

//--- design/icache_pipeline.sv
// TL and TV stage registers, tag compare
// lowest-way hit choice and instruction select

module icache_pipeline
  import icache_pkg::*;
(
  input  logic                              clk_i,
  input  logic                              reset_i,
  input  logic                              lookup_en_i,
  input  addr_fields_s                      vaddr_i,
  input  logic [ptag_width-1:0]             ptag_i,
  input  logic                              ptag_v_i,
  input  logic [ways-1:0][tag_width-1:0]    tags_i,
  input  logic [ways-1:0]                   valid_i,
  input  logic [ways-1:0][dword_width-1:0]  bank_data_i,
  output logic [instr_width-1:0]            data_o,
  output logic                              data_v_o,
  output logic                              tv_valid_o,
  output logic                              tv_hit_o,
  output way_id_t                           tv_hit_way_o,
  output logic [ways-1:0]                   tv_way_valid_o,
  output addr_fields_s                      tv_addr_o
);

  // TL stage
  logic         tl_v_r;
  addr_fields_s vaddr_tl_r;

  // TV stage
  logic                             tv_v_r;
  logic                             tv_we;
  addr_fields_s                     paddr_tv_r;
  logic [ways-1:0][tag_width-1:0]   tags_tv_r;
  logic [ways-1:0]                  valid_tv_r;
  logic [ways-1:0][dword_width-1:0] data_tv_r;

  logic [ways-1:0]        hit_vec;
  logic [dword_width-1:0] dword_sel;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      tl_v_r <= 1'b0;
    end else begin
      tl_v_r <= lookup_en_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (lookup_en_i) begin
      vaddr_tl_r <= vaddr_i;
    end
  end

  // lookup without translation is dropped
  assign tv_we = tl_v_r && ptag_v_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      tv_v_r <= 1'b0;
    end else begin
      tv_v_r <= tv_we;
    end
  end

  always_ff @(posedge clk_i) begin
    if (tv_we) begin
      paddr_tv_r <= {ptag_i, vaddr_tl_r[page_offset_width-1:0]};
      tags_tv_r  <= tags_i;
      valid_tv_r <= valid_i;
      data_tv_r  <= bank_data_i;
    end
  end

  for (genvar i = 0; i < ways; i++) begin : g_cmp
    assign hit_vec[i] = valid_tv_r[i] && (tags_tv_r[i] == paddr_tv_r.tag);
  end

  // lowest hitting way wins
  always_comb begin
    tv_hit_way_o = '0;
    for (int i = ways - 1; i >= 0; i--) begin
      if (hit_vec[i]) begin
        tv_hit_way_o = way_id_t'(i);
      end
    end
  end

  assign tv_hit_o       = |hit_vec;
  assign tv_valid_o     = tv_v_r;
  assign tv_way_valid_o = valid_tv_r;
  assign tv_addr_o      = paddr_tv_r;

  // undo the bank swizzle
  assign dword_sel = data_tv_r[tv_hit_way_o ^ paddr_tv_r.word_offset];
  assign data_o    = paddr_tv_r.byte_offset[2] ? dword_sel[instr_width+:instr_width]
                                               : dword_sel[instr_width-1:0];
  assign data_v_o  = tv_v_r && tv_hit_o;

  // a hit matches exactly one way
  a_hit_unique: assert property (
    @(posedge clk_i) disable iff (reset_i)
    data_v_o |-> $onehot(hit_vec)
  );

endmodule

//--- design/icache_lru.sv
// tree pseudo-LRU bits per set, updated on TV hits
// victim choice, invalid ways first

module icache_lru
  import icache_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   reset_i,
  input  logic                   tv_valid_i,
  input  logic                   tv_hit_i,
  input  way_id_t                tv_hit_way_i,
  input  logic [index_width-1:0] tv_index_i,
  input  logic [ways-1:0]        tv_way_valid_i,
  output way_id_t                victim_way_o
);

  // bit 0 root, bit 1 left pair, bit 2 right pair
  logic [lru_width-1:0] lru_r [sets];
  logic [lru_width-1:0] lru_cur;
  way_id_t              lru_way;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int s = 0; s < sets; s++) begin
        lru_r[s] <= '0;
      end
    end else if (tv_valid_i && tv_hit_i) begin
      // point root away from the half just used
      lru_r[tv_index_i][0] <= ~tv_hit_way_i[1];
      if (!tv_hit_way_i[1]) begin
        lru_r[tv_index_i][1] <= ~tv_hit_way_i[0];
      end else begin
        lru_r[tv_index_i][2] <= ~tv_hit_way_i[0];
      end
    end
  end

  assign lru_cur = lru_r[tv_index_i];

  // follow the tree bits
  assign lru_way = lru_cur[0] ? {1'b1, lru_cur[2]} : {1'b0, lru_cur[1]};

  always_comb begin
    victim_way_o = lru_way;
    for (int i = ways - 1; i >= 0; i--) begin
      if (!tv_way_valid_i[i]) begin
        victim_way_o = way_id_t'(i);
      end
    end
  end

endmodule

//--- design/icache_miss_ctrl.sv
// array port arbitration, miss request and metadata
// outstanding-miss tracker

module icache_miss_ctrl
  import icache_pkg::*;
(
  input  logic         clk_i,
  input  logic         reset_i,
  input  logic         vaddr_v_i,
  output logic         vaddr_ready_o,
  input  logic         fill_v_i,
  output logic         fill_ready_o,
  output logic         lookup_en_o,
  output logic         fill_en_o,
  input  logic         tv_valid_i,
  input  logic         tv_hit_i,
  input  addr_fields_s tv_addr_i,
  input  way_id_t      victim_way_i,
  input  logic         cache_req_ready_i,
  input  logic         cache_req_complete_i,
  output cache_req_s   cache_req_o,
  output logic         cache_req_v_o,
  output cache_meta_s  cache_req_meta_o,
  output logic         cache_req_meta_v_o,
  output logic         miss_o
);

  logic    miss_tv;
  logic    outstanding_r;
  way_id_t victim_r;

  assign miss_tv       = tv_valid_i && !tv_hit_i;
  assign vaddr_ready_o = cache_req_ready_i && !cache_req_v_o && !outstanding_r;

  // lookups own the array port
  assign lookup_en_o  = vaddr_v_i && vaddr_ready_o;
  assign fill_en_o    = fill_v_i && !lookup_en_o;
  assign fill_ready_o = !lookup_en_o;

  // no ready means no request, fetch replays
  assign cache_req_v_o    = miss_tv && cache_req_ready_i && !outstanding_r;
  assign cache_req_o.addr = {tv_addr_i.tag, tv_addr_i.index,
                             {(word_offset_width + byte_offset_width){1'b0}}};

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      cache_req_meta_v_o <= 1'b0;
      outstanding_r      <= 1'b0;
    end else begin
      cache_req_meta_v_o <= cache_req_v_o;
      if (cache_req_v_o) begin
        outstanding_r <= 1'b1;
      end else if (cache_req_complete_i) begin
        outstanding_r <= 1'b0;
      end
    end
  end

  // victim captured in the request cycle
  always_ff @(posedge clk_i) begin
    if (cache_req_v_o) begin
      victim_r <= victim_way_i;
    end
  end

  assign cache_req_meta_o.victim = victim_r;
  assign miss_o                  = miss_tv || outstanding_r;

  // one request per completion
  a_single_req: assert property (
    @(posedge clk_i) disable iff (reset_i)
    cache_req_v_o |=> (!cache_req_v_o until_with cache_req_complete_i)
  );

endmodule

//--- design/icache_top.sv
// instruction cache top level
// connects control, arrays, pipeline and replacement

module icache_top
  import icache_pkg::*;
(
  input  logic                    clk_i,
  input  logic                    reset_i,

  // lookup and translation
  input  addr_fields_s            vaddr_i,
  input  logic                    vaddr_v_i,
  output logic                    vaddr_ready_o,
  input  logic [ptag_width-1:0]   ptag_i,
  input  logic                    ptag_v_i,

  // result
  output logic [instr_width-1:0]  data_o,
  output logic                    data_v_o,
  output logic                    miss_o,

  // coherence engine side
  output cache_req_s              cache_req_o,
  output logic                    cache_req_v_o,
  input  logic                    cache_req_ready_i,
  output cache_meta_s             cache_req_meta_o,
  output logic                    cache_req_meta_v_o,
  input  fill_pkt_s               fill_pkt_i,
  input  logic                    fill_v_i,
  output logic                    fill_ready_o,
  input  logic                    cache_req_complete_i
);

  logic                             lookup_en;
  logic                             fill_en;
  logic [ways-1:0][tag_width-1:0]   tags;
  logic [ways-1:0]                  valid;
  logic [ways-1:0][dword_width-1:0] bank_data;
  logic                             tv_valid;
  logic                             tv_hit;
  way_id_t                          tv_hit_way;
  logic [ways-1:0]                  tv_way_valid;
  addr_fields_s                     tv_addr;
  way_id_t                          victim_way;

  icache_miss_ctrl i_miss_ctrl (
    .clk_i                (clk_i),
    .reset_i              (reset_i),
    .vaddr_v_i            (vaddr_v_i),
    .vaddr_ready_o        (vaddr_ready_o),
    .fill_v_i             (fill_v_i),
    .fill_ready_o         (fill_ready_o),
    .lookup_en_o          (lookup_en),
    .fill_en_o            (fill_en),
    .tv_valid_i           (tv_valid),
    .tv_hit_i             (tv_hit),
    .tv_addr_i            (tv_addr),
    .victim_way_i         (victim_way),
    .cache_req_ready_i    (cache_req_ready_i),
    .cache_req_complete_i (cache_req_complete_i),
    .cache_req_o          (cache_req_o),
    .cache_req_v_o        (cache_req_v_o),
    .cache_req_meta_o     (cache_req_meta_o),
    .cache_req_meta_v_o   (cache_req_meta_v_o),
    .miss_o               (miss_o)
  );

  icache_tag_array i_tag_array (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .lookup_en_i    (lookup_en),
    .lookup_index_i (vaddr_i.index),
    .fill_en_i      (fill_en),
    .fill_pkt_i     (fill_pkt_i),
    .tags_o         (tags),
    .valid_o        (valid)
  );

  icache_data_banks i_data_banks (
    .clk_i           (clk_i),
    .lookup_en_i     (lookup_en),
    .lookup_index_i  (vaddr_i.index),
    .lookup_offset_i (vaddr_i.word_offset),
    .fill_en_i       (fill_en),
    .fill_pkt_i      (fill_pkt_i),
    .bank_data_o     (bank_data)
  );

  icache_pipeline i_pipeline (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .lookup_en_i    (lookup_en),
    .vaddr_i        (vaddr_i),
    .ptag_i         (ptag_i),
    .ptag_v_i       (ptag_v_i),
    .tags_i         (tags),
    .valid_i        (valid),
    .bank_data_i    (bank_data),
    .data_o         (data_o),
    .data_v_o       (data_v_o),
    .tv_valid_o     (tv_valid),
    .tv_hit_o       (tv_hit),
    .tv_hit_way_o   (tv_hit_way),
    .tv_way_valid_o (tv_way_valid),
    .tv_addr_o      (tv_addr)
  );

  icache_lru i_lru (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .tv_valid_i     (tv_valid),
    .tv_hit_i       (tv_hit),
    .tv_hit_way_i   (tv_hit_way),
    .tv_index_i     (tv_addr.index),
    .tv_way_valid_i (tv_way_valid),
    .victim_way_o   (victim_way)
  );

endmodule

//--- verif/icache_checker.sv
// reference model of the cache with tags, valid bits, data and tree LRU
// cycle by cycle comparison of the DUT ports and per-test counts

module icache_checker
  import icache_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   reset_i,
  input  addr_fields_s           vaddr_i,
  input  logic                   vaddr_v_i,
  input  logic                   vaddr_ready_i,
  input  logic [ptag_width-1:0]  ptag_i,
  input  logic                   ptag_v_i,
  input  logic [instr_width-1:0] data_i,
  input  logic                   data_v_i,
  input  logic                   miss_i,
  input  cache_req_s             cache_req_i,
  input  logic                   cache_req_v_i,
  input  logic                   cache_req_ready_i,
  input  cache_meta_s            cache_req_meta_i,
  input  logic                   cache_req_meta_v_i,
  input  fill_pkt_s              fill_pkt_i,
  input  logic                   fill_v_i,
  input  logic                   fill_ready_i,
  input  logic                   cache_req_complete_i,
  input  logic                   done_i,
  output logic                   report_done_o,
  output logic                   fail_o
);

  localparam int t_miss  = 0;
  localparam int t_hit   = 1;
  localparam int t_lru   = 2;
  localparam int t_inval = 3;
  localparam int t_bp    = 4;

  string names [5] = '{"miss_request", "hit_data", "lru_victim", "invalidate", "backpressure"};
  int    checks [5] = '{default: 0};
  int    errors [5] = '{default: 0};
  int    total_checks;
  int    total_errors;

  // cache contents
  logic [tag_width-1:0]   m_tag [sets][ways];
  logic                   m_valid [sets][ways];
  logic [dword_width-1:0] m_data [sets][ways][block_words];
  logic                   m_root [sets];
  logic                   m_left [sets];
  logic                   m_right [sets];
  logic                   m_disturbed [sets];

  // pipeline copies taken at the array read
  logic                   tl_v;
  addr_fields_s           tl_vaddr;
  logic [tag_width-1:0]   tl_tag [ways];
  logic                   tl_valid [ways];
  logic [dword_width-1:0] tl_word [ways];
  logic                   tl_dist;
  logic                   tv_v;
  addr_fields_s           tv_paddr;
  logic [tag_width-1:0]   tv_tag [ways];
  logic                   tv_valid [ways];
  logic [dword_width-1:0] tv_word [ways];
  logic                   tv_dist;

  logic                   outstanding;
  logic                   meta_pending;
  int                     meta_victim;
  int                     meta_test;

  task automatic check(input int test, input logic ok, input string msg);
    checks[test]++;
    if (ok !== 1'b1) begin
      errors[test]++;
      $display("error at time %0t: %s", $time, msg);
    end
  endtask

  task automatic apply_fill(input fill_pkt_s p);
    case (p.op)
      fill_set_clear: begin
        for (int w = 0; w < ways; w++) begin
          m_valid[p.index][w] = 1'b0;
        end
        m_disturbed[p.index] = 1'b1;
      end
      fill_invalidate: begin
        m_valid[p.index][p.way] = 1'b0;
        m_disturbed[p.index]    = 1'b1;
      end
      fill_set_tag: begin
        m_tag[p.index][p.way]   = p.payload.tag_info.tag;
        m_valid[p.index][p.way] = p.payload.tag_info.valid;
        m_disturbed[p.index]    = 1'b0;
      end
      default: begin
        for (int w = 0; w < block_words; w++) begin
          m_data[p.index][p.way][w] = p.payload.block[w];
        end
      end
    endcase
  endtask

  always @(negedge clk_i) begin : step
    logic        hit;
    int          hit_way;
    logic        miss_tv;
    logic        exp_req;
    logic        exp_ready;
    logic        lookup;
    logic        all_valid;
    int          victim;
    int          lru_way;
    int          idx;
    int          test;
    logic [63:0] dword;
    logic [31:0] exp_data;
    if (reset_i) begin
      for (int s = 0; s < sets; s++) begin
        for (int w = 0; w < ways; w++) begin
          m_valid[s][w] = 1'b0;
        end
        m_root[s]      = 1'b0;
        m_left[s]      = 1'b0;
        m_right[s]     = 1'b0;
        m_disturbed[s] = 1'b0;
      end
      tl_v         = 1'b0;
      tv_v         = 1'b0;
      outstanding  = 1'b0;
      meta_pending = 1'b0;
      meta_test    = t_miss;
    end else begin
      hit     = 1'b0;
      hit_way = 0;
      for (int w = 0; w < ways; w++) begin
        if (!hit && tv_v && tv_valid[w] && tv_tag[w] == tv_paddr.tag) begin
          hit     = 1'b1;
          hit_way = w;
        end
      end
      miss_tv   = tv_v && !hit;
      exp_req   = miss_tv && cache_req_ready_i && !outstanding;
      exp_ready = cache_req_ready_i && !exp_req && !outstanding;
      lookup    = vaddr_v_i && exp_ready;
      idx       = tv_paddr.index;

      // lowest invalid way or else the tree LRU way
      all_valid = 1'b1;
      victim    = 0;
      for (int w = 0; w < ways; w++) begin
        if (all_valid && !tv_valid[w]) begin
          all_valid = 1'b0;
          victim    = w;
        end
      end
      if (m_root[idx]) begin
        lru_way = m_right[idx] ? 3 : 2;
      end else begin
        lru_way = m_left[idx] ? 1 : 0;
      end
      if (all_valid) begin
        victim = lru_way;
      end

      test = tv_dist ? t_inval : t_hit;
      check(test, data_v_i === (tv_v && hit), "data_v_o differs from the model");
      if (tv_v && hit) begin
        dword    = tv_word[hit_way];
        exp_data = tv_paddr.byte_offset[2] ? dword[63:32] : dword[31:0];
        check(test, data_i === exp_data,
              $sformatf("data_o is %h, expected %h", data_i, exp_data));
      end
      test = (outstanding || !cache_req_ready_i) ? t_bp : (tv_dist ? t_inval : t_miss);
      check(test, miss_i === (miss_tv || outstanding), "miss_o differs from the model");
      check(test, cache_req_v_i === exp_req, "cache_req_v_o differs from the model");
      if (exp_req) begin
        check(t_miss, cache_req_i.addr === {tv_paddr[31:5], 5'b0},
              $sformatf("request address %h for line %h", cache_req_i.addr, tv_paddr));
      end
      check(t_bp, vaddr_ready_i === exp_ready, "vaddr_ready_o differs from the model");
      check(t_bp, fill_ready_i === !lookup, "fill_ready_o differs from the model");
      check(meta_test, cache_req_meta_v_i === meta_pending, "metadata valid out of place");
      if (meta_pending) begin
        check(meta_test, cache_req_meta_i.victim === way_id_t'(meta_victim),
              $sformatf("victim way %0d, expected %0d", cache_req_meta_i.victim, meta_victim));
      end

      // state changes at the next rising edge
      if (hit) begin
        case (hit_way)
          0: begin
            m_root[idx] = 1'b1;
            m_left[idx] = 1'b1;
          end
          1: begin
            m_root[idx] = 1'b1;
            m_left[idx] = 1'b0;
          end
          2: begin
            m_root[idx]  = 1'b0;
            m_right[idx] = 1'b1;
          end
          default: begin
            m_root[idx]  = 1'b0;
            m_right[idx] = 1'b0;
          end
        endcase
      end
      meta_pending = exp_req;
      meta_victim  = victim;
      meta_test    = (exp_req && all_valid) ? t_lru : t_miss;
      if (exp_req) begin
        outstanding = 1'b1;
      end else if (cache_req_complete_i) begin
        outstanding = 1'b0;
      end
      tv_v = tl_v && ptag_v_i;
      if (tv_v) begin
        tv_paddr = {ptag_i, tl_vaddr[page_offset_width-1:0]};
        tv_tag   = tl_tag;
        tv_valid = tl_valid;
        tv_word  = tl_word;
        tv_dist  = tl_dist;
      end
      tl_v = lookup;
      if (lookup) begin
        tl_vaddr = vaddr_i;
        tl_dist  = m_disturbed[vaddr_i.index];
        for (int w = 0; w < ways; w++) begin
          tl_tag[w]   = m_tag[vaddr_i.index][w];
          tl_valid[w] = m_valid[vaddr_i.index][w];
          tl_word[w]  = m_data[vaddr_i.index][w][vaddr_i.word_offset];
        end
      end
      if (fill_v_i && !lookup) begin
        apply_fill(fill_pkt_i);
      end
    end
  end

  initial begin
    report_done_o = 1'b0;
    fail_o        = 1'b0;
    total_checks  = 0;
    total_errors  = 0;
    wait (done_i === 1'b1);
    for (int t = 0; t < 5; t++) begin
      $display("test %-12s %0d checks, %0d errors", names[t], checks[t], errors[t]);
      if (checks[t] == 0) begin
        $display("test %s never ran a single check", names[t]);
        fail_o = 1'b1;
      end
      total_checks += checks[t];
      total_errors += errors[t];
    end
    $display("all tests: %0d checks, %0d errors", total_checks, total_errors);
    if (total_errors != 0) begin
      fail_o = 1'b1;
    end
    report_done_o = 1'b1;
  end

endmodule

//--- verif/icache_tb.sv
// testbench top for the instruction cache
// clock, reset, random fetch stimulus, coherence engine responder, watchdog

module icache_tb
  import icache_pkg::*;
();

  localparam int n_lookups      = 400;
  localparam int timeout_cycles = n_lookups * 200;

  logic                   clk_i;
  logic                   reset_i;
  addr_fields_s           vaddr_i;
  logic                   vaddr_v_i;
  logic                   vaddr_ready_o;
  logic [ptag_width-1:0]  ptag_i;
  logic                   ptag_v_i;
  logic [instr_width-1:0] data_o;
  logic                   data_v_o;
  logic                   miss_o;
  cache_req_s             cache_req_o;
  logic                   cache_req_v_o;
  logic                   cache_req_ready_i;
  cache_meta_s            cache_req_meta_o;
  logic                   cache_req_meta_v_o;
  fill_pkt_s              fill_pkt_i;
  logic                   fill_v_i;
  logic                   fill_ready_o;
  logic                   cache_req_complete_i;

  integer                 seed;
  int                     accepted_count;
  logic                   pend_v;
  logic                   keep_ptag;
  logic [ptag_width-1:0]  pend_ptag;
  logic                   engine_busy;
  logic                   sim_done;
  logic                   report_done;
  logic                   check_fail;
  logic [paddr_width-1:0] req_addr;
  way_id_t                victim;
  int                     disturb;
  logic [index_width-1:0] dset;
  way_id_t                dway;
  fill_pkt_s              pkt;

  icache_top i_dut (.*);

  icache_checker i_checker (
    .clk_i                (clk_i),
    .reset_i              (reset_i),
    .vaddr_i              (vaddr_i),
    .vaddr_v_i            (vaddr_v_i),
    .vaddr_ready_i        (vaddr_ready_o),
    .ptag_i               (ptag_i),
    .ptag_v_i             (ptag_v_i),
    .data_i               (data_o),
    .data_v_i             (data_v_o),
    .miss_i               (miss_o),
    .cache_req_i          (cache_req_o),
    .cache_req_v_i        (cache_req_v_o),
    .cache_req_ready_i    (cache_req_ready_i),
    .cache_req_meta_i     (cache_req_meta_o),
    .cache_req_meta_v_i   (cache_req_meta_v_o),
    .fill_pkt_i           (fill_pkt_i),
    .fill_v_i             (fill_v_i),
    .fill_ready_i         (fill_ready_o),
    .cache_req_complete_i (cache_req_complete_i),
    .done_i               (sim_done),
    .report_done_o        (report_done),
    .fail_o               (check_fail)
  );

  // three sets in use
  function automatic logic [index_width-1:0] set_of(input int k);
    return (k == 0) ? 6'd3 : ((k == 1) ? 6'd20 : 6'd57);
  endfunction

  // six lines in the first set, four in the second, two in the third
  function automatic logic [paddr_width-1:0] line_addr(input int line, input int word,
                                                        input logic half);
    logic [tag_width-1:0]   tag;
    logic [index_width-1:0] index;
    tag   = tag_width'(21'h0a5c0 + line * 21'h0133);
    index = set_of((line < 6) ? 0 : ((line < 10) ? 1 : 2));
    return {tag, index, 2'(word), half, 2'b00};
  endfunction

  // block contents hashed from the block address and word number
  function automatic logic [dword_width-1:0] block_word(input logic [31:0] addr, input int w);
    logic [31:0] a;
    a = addr ^ (w * 32'h01000193);
    return {a * 32'h9e3779b1, ~a ^ 32'h3c6ef372};
  endfunction

  task automatic send_fill(input fill_pkt_s p);
    logic accepted;
    fill_pkt_i = p;
    fill_v_i   = 1'b1;
    accepted   = 1'b0;
    while (!accepted) begin
      @(negedge clk_i);
      accepted = fill_ready_o;
      @(posedge clk_i);
      #1;
    end
    fill_v_i = 1'b0;
  endtask

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  // fetch side
  initial begin
    seed                 = 69;
    reset_i              = 1'b1;
    vaddr_i              = '0;
    vaddr_v_i            = 1'b0;
    ptag_i               = '0;
    ptag_v_i             = 1'b0;
    cache_req_ready_i    = 1'b0;
    fill_pkt_i           = '0;
    fill_v_i             = 1'b0;
    cache_req_complete_i = 1'b0;
    engine_busy          = 1'b0;
    sim_done             = 1'b0;
    accepted_count       = 0;
    pend_v               = 1'b0;
    pend_ptag            = '0;
    repeat (8) @(posedge clk_i);
    #1;
    reset_i = 1'b0;
    while (accepted_count < n_lookups) begin
      ptag_v_i          = pend_v;
      ptag_i            = pend_ptag;
      cache_req_ready_i = (($random(seed) & 7) != 0);
      vaddr_v_i         = (($random(seed) & 3) != 0);
      keep_ptag         = (($random(seed) & 15) != 0);
      vaddr_i = line_addr($unsigned($random(seed)) % 12, $random(seed) & 3, $random(seed));
      @(negedge clk_i);
      pend_v = 1'b0;
      if (vaddr_v_i && vaddr_ready_o) begin
        accepted_count++;
        pend_v    = keep_ptag;
        pend_ptag = vaddr_i[paddr_width-1:page_offset_width];
      end
      @(posedge clk_i);
      #1;
    end
    ptag_v_i          = pend_v;
    ptag_i            = pend_ptag;
    vaddr_v_i         = 1'b0;
    cache_req_ready_i = 1'b1;
    @(posedge clk_i);
    #1;
    ptag_v_i = 1'b0;
    // let the last miss get served
    repeat (4) @(posedge clk_i);
    wait (!engine_busy);
    repeat (4) @(posedge clk_i);
    sim_done = 1'b1;
  end

  // coherence engine, one request at a time
  initial begin
    forever begin
      @(negedge clk_i);
      if (cache_req_v_o) begin
        engine_busy = 1'b1;
        req_addr    = cache_req_o.addr;
        @(negedge clk_i);
        victim  = cache_req_meta_o.victim;
        disturb = $unsigned($random(seed)) % 8;
        dset    = set_of($unsigned($random(seed)) % 3);
        dway    = way_id_t'($random(seed));
        @(posedge clk_i);
        #1;
        if (disturb < 2) begin
          pkt       = '0;
          pkt.op    = (disturb == 0) ? fill_set_clear : fill_invalidate;
          pkt.index = dset;
          pkt.way   = dway;
          send_fill(pkt);
        end
        pkt                      = '0;
        pkt.op                   = fill_set_tag;
        pkt.index                = req_addr[10:5];
        pkt.way                  = victim;
        pkt.payload.tag_info.tag = req_addr[31:11];
        pkt.payload.tag_info.valid = 1'b1;
        send_fill(pkt);
        pkt.op = fill_write_data;
        for (int w = 0; w < block_words; w++) begin
          pkt.payload.block[w] = block_word(req_addr, w);
        end
        send_fill(pkt);
        cache_req_complete_i = 1'b1;
        @(posedge clk_i);
        #1;
        cache_req_complete_i = 1'b0;
        engine_busy          = 1'b0;
      end
    end
  end

  initial begin
    #(timeout_cycles * 10);
    $display("timeout: the run did not finish within %0d cycles", timeout_cycles);
    $display("Something failed");
    $finish;
  end

  initial begin
    wait (report_done === 1'b1);
    if (check_fail) begin
      $display("Something failed");
    end else begin
      $display("Everything OK");
    end
    $finish;
  end

endmodule

//--- all.f
design/icache_pkg.sv
design/icache_tag_array.sv
design/icache_data_banks.sv
design/icache_pipeline.sv
design/icache_lru.sv
design/icache_miss_ctrl.sv
design/icache_top.sv
verif/icache_checker.sv
verif/icache_tb.sv
